// ==== build.f ====
common/kcpu_regs_pkg.sv
common/kcpu_cmd_pkg.sv
regs/kcpu_regs.sv
regs/kcpu_psh_seq.sv
source/kcpu_stack_ram.sv
source/kcpu_cmd_ctrl.sv
source/kcpu_stack_unit.sv
verif/kcpu_stack_tb.sv

// ==== verif/kcpu_stack_stimulus.txt ====
# columns (hex): op src dst data mask ussel expected_rsp
# op 0 LOAD 1 READ 2 TFR 3 EXG 4 PUSH 5 PULL; reg 0 A 1 B 2 X 3 Y 4 S 5 U 8 DP 9 CC a PC
1 0 0 0000 00 0 0000
1 1 0 0000 00 0 0000
1 2 0 0000 00 0 0000
1 3 0 0000 00 0 0000
1 4 0 0000 00 0 0000
1 5 0 0000 00 0 0000
1 8 0 0000 00 0 0000
1 9 0 0000 00 0 0000
1 a 0 0000 00 0 0000
0 0 0 1234 00 0 0000
0 0 1 abcd 00 0 0000
0 0 2 2345 00 0 0000
0 0 3 6789 00 0 0000
0 0 4 0180 00 0 0000
0 0 5 0140 00 0 0000
0 0 8 7712 00 0 0000
0 0 9 00d0 00 0 0000
0 0 a c0de 00 0 0000
1 0 0 0000 00 0 0034
1 1 0 0000 00 0 00cd
1 2 0 0000 00 0 2345
1 3 0 0000 00 0 6789
1 4 0 0000 00 0 0180
1 5 0 0000 00 0 0140
1 8 0 0000 00 0 0012
1 9 0 0000 00 0 00d0
1 a 0 0000 00 0 c0de
4 0 0 0000 ff 0 0000
1 4 0 0000 00 0 0174
0 0 0 0011 00 0 0000
0 0 9 0044 00 0 0000
0 0 2 5555 00 0 0000
0 0 a 8888 00 0 0000
5 0 0 0000 ff 0 0000
1 0 0 0000 00 0 0034
1 9 0 0000 00 0 00d0
1 2 0 0000 00 0 2345
1 3 0 0000 00 0 6789
1 a 0 0000 00 0 c0de
1 4 0 0000 00 0 0180
4 0 0 0000 40 1 0000
1 5 0 0000 00 0 013e
0 0 4 0000 00 0 0000
5 0 0 0000 40 1 0000
1 4 0 0000 00 0 0180
1 5 0 0000 00 0 0140
4 0 0 0000 00 0 0000
1 4 0 0000 00 0 0180
2 0 2 0000 00 0 0000
1 2 0 0000 00 0 ff34
2 3 1 0000 00 0 0000
1 1 0 0000 00 0 0089
3 0 3 0000 00 0 0000
1 0 0 0000 00 0 0089
1 3 0 0000 00 0 ff34
2 8 2 0000 00 0 0000
1 2 0 0000 00 0 0000

// ==== verif/kcpu_stack_tb.sv ====
/*
 * testbench for the KCPU register and stack unit
 * reads commands and expected read data from the stimulus file,
 * runs the four-phase command handshake and checks responses and latency
 */
`timescale 1ns/1ns

module kcpu_stack_tb;

    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DLY   = 10;
    localparam int ACK_TIMEOUT = 400;

    logic                     clk;
    logic                     rst;
    logic                     cmd_req;
    kcpu_cmd_pkg::cmd_t       cmd;
    logic                     cmd_ack;
    kcpu_cmd_pkg::rsp_t       rsp;

    integer                   seed;
    integer                   fd;
    integer                   fields;
    integer                   code;
    integer                   gap;
    int                       n_cmds;
    string                    line;
    logic [31:0]              f_op;
    logic [31:0]              f_src;
    logic [31:0]              f_dst;
    logic [31:0]              f_data;
    logic [31:0]              f_mask;
    logic [31:0]              f_us;
    logic [31:0]              f_rsp;
    kcpu_cmd_pkg::cmd_t       next_cmd;

    kcpu_stack_unit #(
        .RAM_AW (8)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .cmd_req (cmd_req),
        .cmd     (cmd),
        .cmd_ack (cmd_ack),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("*** FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            fail_run("value mismatch, simulation stopped");
        end
    endtask

    // counts edges until cmd_ack is seen high, sampled after the drive delay
    task automatic wait_ack_rise(output int edges);
        edges = 0;
        while (cmd_ack !== 1'b1) begin
            if (edges >= ACK_TIMEOUT)
                fail_run("timeout: cmd_ack never rose after cmd_req");
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
        end
    endtask

    task automatic wait_ack_fall(output int edges);
        edges = 0;
        while (cmd_ack !== 1'b0) begin
            if (edges >= ACK_TIMEOUT)
                fail_run("timeout: cmd_ack never fell after cmd_req dropped");
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
        end
    endtask

    // CC reads name the flags so a mismatch is easy to read
    function automatic string rsp_label(kcpu_cmd_pkg::cmd_t c, logic [15:0] exp_rsp);
        if (c.op == kcpu_cmd_pkg::OP_READ && c.src == kcpu_regs_pkg::REG_CC)
            return $sformatf("rsp.data of READ CC (expected E=%0b F=%0b I=%0b)",
                             exp_rsp[kcpu_regs_pkg::CC_E], exp_rsp[kcpu_regs_pkg::CC_F],
                             exp_rsp[kcpu_regs_pkg::CC_I]);
        return $sformatf("rsp.data of op %0d src %0h dst %0h", c.op, c.src, c.dst);
    endfunction

    task automatic run_command(input kcpu_cmd_pkg::cmd_t c, input logic [15:0] exp_rsp);
        int  edges;
        bit  is_seq;
        is_seq  = c.op == kcpu_cmd_pkg::OP_PUSH || c.op == kcpu_cmd_pkg::OP_PULL;
        cmd     = c;
        cmd_req = 1'b1;
        wait_ack_rise(edges);
        // register-only commands answer on the second edge
        if (!is_seq)
            check_value("cmd_ack rise latency in edges", edges, 2);
        check_value(rsp_label(c, exp_rsp), rsp.data, exp_rsp);
        cmd_req = 1'b0;
        wait_ack_fall(edges);
        check_value("cmd_ack fall latency in edges", edges, 1);
    endtask

    initial begin
        rst     = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        seed    = 32'h118449bf;
        n_cmds  = 0;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        check_value("cmd_ack after reset", cmd_ack, 0);

        fd = $fopen("verif/kcpu_stack_stimulus.txt", "r");
        if (fd == 0)
            fail_run("could not open verif/kcpu_stack_stimulus.txt");

        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            fields = $sscanf(line, "%h %h %h %h %h %h %h",
                             f_op, f_src, f_dst, f_data, f_mask, f_us, f_rsp);
            // comment and blank lines do not parse into seven fields
            if (code > 0 && fields == 7) begin
                next_cmd.op    = kcpu_cmd_pkg::cmd_op_e'(f_op[2:0]);
                next_cmd.src   = kcpu_regs_pkg::reg_code_e'(f_src[3:0]);
                next_cmd.dst   = kcpu_regs_pkg::reg_code_e'(f_dst[3:0]);
                next_cmd.data  = f_data[15:0];
                next_cmd.mask  = f_mask[7:0];
                next_cmd.ussel = f_us[0];
                run_command(next_cmd, f_rsp[15:0]);
                n_cmds++;
                // random idle time between commands
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end
        end
        $fclose(fd);

        if (n_cmds == 0) begin
            fail_run("stimulus file held no commands");
        end else begin
            $display("%0d commands run", n_cmds);
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== source/kcpu_stack_unit.sv ====
/*
 * register and stack unit of the KCPU core
 * command controller, register file, push/pull sequencer
 * and stack RAM
 */
`timescale 1ns/1ns

module kcpu_stack_unit #(
    parameter int RAM_AW = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_req,
    input  kcpu_cmd_pkg::cmd_t cmd,
    output logic               cmd_ack,
    output kcpu_cmd_pkg::rsp_t rsp
);

    kcpu_regs_pkg::reg_snap_t regs;
    kcpu_regs_pkg::reg_code_e wr_dst;
    logic [15:0]              src_mux;
    logic [15:0]              wr_data;
    logic                     wr_en;
    logic                     exg_en;
    logic                     seq_go;
    logic                     seq_done;
    logic                     is_pull;
    logic [7:0]               mask;
    logic                     ussel;

    // push/pull path
    logic [7:0]               psh_sel;
    logic                     psh_hilon;
    logic                     pul_en;
    logic                     pshdec;
    logic [7:0]               pul_data;
    logic [7:0]               psh_mux;
    logic [7:0]               psh_bit;
    logic [15:0]              psh_addr;

    // stack RAM bus
    logic                     stk_req;
    kcpu_cmd_pkg::stk_req_t   stk;
    logic                     stk_ack;
    logic [7:0]               rdata;

    kcpu_cmd_ctrl u_ctrl (.*);

    // TFR/EXG codes come straight from the held command
    kcpu_regs u_regs (
        .*,
        .src       (cmd.src),
        .dst       (cmd.dst),
        .psh_ussel (ussel),
        .dst_mux   ()
    );

    kcpu_psh_seq u_seq (.*);

    kcpu_stack_ram #(
        .RAM_AW (RAM_AW)
    ) u_ram (.*);

endmodule

// ==== source/kcpu_cmd_ctrl.sv ====
/*
 * command port controller
 * four-phase handshake with the outside and dispatch of
 * load, read, transfer, exchange, push and pull
 */
`timescale 1ns/1ns

module kcpu_cmd_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_req,
    input  kcpu_cmd_pkg::cmd_t       cmd,
    input  kcpu_regs_pkg::reg_snap_t regs,
    input  logic [15:0]              src_mux,
    input  logic                     seq_done,
    output logic                     cmd_ack,
    output kcpu_cmd_pkg::rsp_t       rsp,
    output logic                     wr_en,
    output kcpu_regs_pkg::reg_code_e wr_dst,
    output logic [15:0]              wr_data,
    output logic                     exg_en,
    output logic                     seq_go,
    output logic                     is_pull,
    output logic [7:0]               mask,
    output logic                     ussel
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_EXEC,
        C_SEQ,
        C_ACK
    } state_e;

    state_e             state;
    kcpu_cmd_pkg::cmd_t cmd_q;
    logic [15:0]        rd_val;
    logic               use_seq;

    // plain reads of byte registers, no FF padding
    always_comb begin
        case (cmd_q.src)
            kcpu_regs_pkg::REG_A:  rd_val = {8'h00, regs.a};
            kcpu_regs_pkg::REG_B:  rd_val = {8'h00, regs.b};
            kcpu_regs_pkg::REG_DP: rd_val = {8'h00, regs.dp};
            kcpu_regs_pkg::REG_CC: rd_val = {8'h00, regs.cc};
            kcpu_regs_pkg::REG_PC: rd_val = regs.pc;
            default:               rd_val = src_mux;
        endcase
    end

    assign use_seq = cmd_q.op == kcpu_cmd_pkg::OP_PUSH || cmd_q.op == kcpu_cmd_pkg::OP_PULL;

    assign wr_en   = state == C_EXEC &&
                     (cmd_q.op == kcpu_cmd_pkg::OP_LOAD || cmd_q.op == kcpu_cmd_pkg::OP_TFR);
    assign wr_dst  = cmd_q.dst;
    assign wr_data = cmd_q.op == kcpu_cmd_pkg::OP_LOAD ? cmd_q.data : src_mux;
    assign exg_en  = state == C_EXEC && cmd_q.op == kcpu_cmd_pkg::OP_EXG;
    assign seq_go  = state == C_SEQ;
    assign is_pull = cmd_q.op == kcpu_cmd_pkg::OP_PULL;
    assign mask    = cmd_q.mask;
    assign ussel   = cmd_q.ussel;
    assign cmd_ack = state == C_ACK;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
        end else begin
            case (state)
                C_IDLE: begin
                    if (cmd_req)
                        state <= C_EXEC;
                end
                C_EXEC: state <= use_seq ? C_SEQ : C_ACK;
                C_SEQ: begin
                    if (seq_done)
                        state <= C_ACK;
                end
                C_ACK: begin
                    if (!cmd_req)
                        state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_IDLE && cmd_req)
            cmd_q <= cmd;
        if (state == C_EXEC)
            rsp.data <= cmd_q.op == kcpu_cmd_pkg::OP_READ ? rd_val : 16'h0000;
    end

endmodule

// ==== source/kcpu_stack_ram.sv ====
/*
 * byte-wide stack RAM
 * answers four-phase read and write requests
 */
`timescale 1ns/1ns

module kcpu_stack_ram #(
    parameter int RAM_AW = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stk_req,
    input  kcpu_cmd_pkg::stk_req_t stk,
    output logic                   stk_ack,
    output logic [7:0]             rdata
);

    logic [7:0] mem [2**RAM_AW];
    logic       start;

    // new request seen while the ack is still low
    assign start = stk_req && !stk_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            stk_ack <= 1'b0;
        else if (start)
            stk_ack <= 1'b1;
        else if (!stk_req)
            stk_ack <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (stk.we)
                mem[stk.addr[RAM_AW-1:0]] <= stk.wdata;
            else
                rdata <= mem[stk.addr[RAM_AW-1:0]];
        end
    end

    // a new request only once the previous ack has dropped
    assert property (@(posedge clk) disable iff (rst)
        $rose(stk_req) |-> !stk_ack);

    // requester holds req and its fields until the ack is seen
    assert property (@(posedge clk) disable iff (rst)
        start |=> stk_req && $stable(stk));

endmodule

// ==== regs/kcpu_psh_seq.sv ====
/*
 * push/pull sequencer
 * walks the register mask a byte at a time and runs
 * the four-phase stack RAM handshake
 */
`timescale 1ns/1ns

module kcpu_psh_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   seq_go,
    input  logic                   is_pull,
    input  logic [7:0]             mask,
    input  logic                   ussel,
    input  logic [7:0]             psh_mux,
    input  logic [7:0]             psh_bit,
    input  logic [15:0]            psh_addr,
    input  logic                   stk_ack,
    input  logic [7:0]             rdata,
    output logic                   seq_done,
    output logic [7:0]             psh_sel,
    output logic                   psh_hilon,
    output logic                   pul_en,
    output logic                   pshdec,
    output logic                   stk_req,
    output kcpu_cmd_pkg::stk_req_t stk,
    output logic [7:0]             pul_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEL,
        S_DEC,
        S_REQ,
        S_REL,
        S_DONE
    } state_e;

    state_e     state;
    logic [7:0] rem;
    logic       wide;
    logic       last_byte;

    // X, Y, the other pointer and PC take two bytes
    assign wide = psh_bit[kcpu_regs_pkg::PSH_X] | psh_bit[kcpu_regs_pkg::PSH_Y] |
                  psh_bit[kcpu_regs_pkg::PSH_OTHER] | psh_bit[kcpu_regs_pkg::PSH_PC];
    // push starts on the low byte, pull on the high one
    assign last_byte = !wide || (psh_hilon != is_pull);

    // pull takes the lowest bit first, so only that one is offered
    assign psh_sel = is_pull ? (rem & (~rem + 8'd1)) : rem;

    assign pshdec   = state == S_DEC;
    assign stk_req  = state == S_REQ;
    assign pul_en   = stk_req && stk_ack && is_pull;
    assign pul_data = rdata;
    assign seq_done = state == S_DONE;
    assign stk      = '{we: !is_pull, addr: psh_addr, wdata: psh_mux};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            rem       <= 8'h00;
            psh_hilon <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (seq_go) begin
                        rem       <= mask;
                        psh_hilon <= is_pull;
                        state     <= S_SEL;
                    end
                end
                S_SEL: begin
                    if (rem == 8'h00)
                        state <= S_DONE;
                    else
                        state <= is_pull ? S_REQ : S_DEC;
                end
                S_DEC: state <= S_REQ;
                S_REQ: begin
                    if (stk_ack)
                        state <= S_REL;
                end
                S_REL: begin
                    // next byte only once the RAM has dropped its ack
                    if (!stk_ack) begin
                        if (last_byte) begin
                            rem       <= rem & ~psh_bit;
                            psh_hilon <= is_pull;
                            state     <= S_SEL;
                        end else begin
                            psh_hilon <= !psh_hilon;
                            state     <= is_pull ? S_REQ : S_DEC;
                        end
                    end
                end
                S_DONE: begin
                    if (!seq_go)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // remaining mask loses exactly one bit it still holds per finished register
    assert property (@(posedge clk) disable iff (rst)
        state == S_REL && !stk_ack && last_byte |->
            $onehot(psh_bit) && (psh_bit & ~rem) == 8'h00);

    // controller keeps the run parameters steady while seq_go is up
    assert property (@(posedge clk) disable iff (rst)
        state != S_IDLE && seq_go |-> $stable(is_pull) && $stable(ussel) && $stable(mask));

endmodule

// ==== regs/kcpu_regs.sv ====
/*
 * register file of the KCPU core
 * A, B, DP, CC, X, Y, U, S and PC with transfer/exchange muxes,
 * push byte selection, pull byte write and U/S stepping
 */
`timescale 1ns/1ns

module kcpu_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  kcpu_regs_pkg::reg_code_e wr_dst,
    input  logic [15:0]              wr_data,
    input  logic                     exg_en,
    input  kcpu_regs_pkg::reg_code_e src,
    input  kcpu_regs_pkg::reg_code_e dst,
    input  logic [7:0]               psh_sel,
    input  logic                     psh_hilon,
    input  logic                     psh_ussel,
    input  logic                     pul_en,
    input  logic                     pshdec,
    input  logic [7:0]               pul_data,
    output kcpu_regs_pkg::reg_snap_t regs,
    output logic [15:0]              src_mux,
    output logic [15:0]              dst_mux,
    output logic [7:0]               psh_mux,
    output logic [7:0]               psh_bit,
    output logic [15:0]              psh_addr
);

    kcpu_regs_pkg::reg_snap_t nx;
    logic [15:0]              other;
    logic [15:0]              word;

    // TFR/EXG view, byte registers read with FF on top
    function automatic logic [15:0] tfr_val(kcpu_regs_pkg::reg_snap_t s,
                                            kcpu_regs_pkg::reg_code_e c);
        case (c)
            kcpu_regs_pkg::REG_A: return {8'hFF, s.a};
            kcpu_regs_pkg::REG_B: return {8'hFF, s.b};
            kcpu_regs_pkg::REG_X: return s.x;
            kcpu_regs_pkg::REG_Y: return s.y;
            kcpu_regs_pkg::REG_S: return s.s;
            kcpu_regs_pkg::REG_U: return s.u;
            default:              return 16'h0000;
        endcase
    endfunction

    // byte registers keep the low byte
    function automatic kcpu_regs_pkg::reg_snap_t put(kcpu_regs_pkg::reg_snap_t s,
                                                     kcpu_regs_pkg::reg_code_e c,
                                                     logic [15:0] v);
        kcpu_regs_pkg::reg_snap_t o;
        o = s;
        case (c)
            kcpu_regs_pkg::REG_A:  o.a  = v[7:0];
            kcpu_regs_pkg::REG_B:  o.b  = v[7:0];
            kcpu_regs_pkg::REG_DP: o.dp = v[7:0];
            kcpu_regs_pkg::REG_CC: o.cc = v[7:0];
            kcpu_regs_pkg::REG_X:  o.x  = v;
            kcpu_regs_pkg::REG_Y:  o.y  = v;
            kcpu_regs_pkg::REG_S:  o.s  = v;
            kcpu_regs_pkg::REG_U:  o.u  = v;
            kcpu_regs_pkg::REG_PC: o.pc = v;
            default: ;
        endcase
        return o;
    endfunction

    function automatic logic [15:0] put_byte(logic [15:0] v, logic hi, logic [7:0] d);
        return hi ? {d, v[7:0]} : {v[15:8], d};
    endfunction

    assign src_mux  = tfr_val(regs, src);
    assign dst_mux  = tfr_val(regs, dst);
    assign psh_addr = psh_ussel ? regs.u : regs.s;
    assign other    = psh_ussel ? regs.s : regs.u;

    // highest offered mask bit wins
    always_comb begin
        psh_bit = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (psh_sel[i])
                psh_bit = 8'h01 << i;
        end
    end

    always_comb begin
        if (psh_bit[kcpu_regs_pkg::PSH_X])
            word = regs.x;
        else if (psh_bit[kcpu_regs_pkg::PSH_Y])
            word = regs.y;
        else if (psh_bit[kcpu_regs_pkg::PSH_OTHER])
            word = other;
        else
            word = regs.pc;

        if (psh_bit[kcpu_regs_pkg::PSH_CC])
            psh_mux = regs.cc;
        else if (psh_bit[kcpu_regs_pkg::PSH_A])
            psh_mux = regs.a;
        else if (psh_bit[kcpu_regs_pkg::PSH_B])
            psh_mux = regs.b;
        else if (psh_bit[kcpu_regs_pkg::PSH_DP])
            psh_mux = regs.dp;
        else
            psh_mux = psh_hilon ? word[15:8] : word[7:0];
    end

    always_comb begin
        nx = regs;
        if (wr_en)
            nx = put(nx, wr_dst, wr_data);
        // both sides of an exchange land on the same edge
        if (exg_en) begin
            nx = put(nx, dst, src_mux);
            nx = put(nx, src, dst_mux);
        end
        if (pshdec) begin
            if (psh_ussel)
                nx.u = regs.u - 16'd1;
            else
                nx.s = regs.s - 16'd1;
        end
        if (pul_en) begin
            if (psh_bit[kcpu_regs_pkg::PSH_CC])
                nx.cc = pul_data;
            else if (psh_bit[kcpu_regs_pkg::PSH_A])
                nx.a = pul_data;
            else if (psh_bit[kcpu_regs_pkg::PSH_B])
                nx.b = pul_data;
            else if (psh_bit[kcpu_regs_pkg::PSH_DP])
                nx.dp = pul_data;
            else if (psh_bit[kcpu_regs_pkg::PSH_X])
                nx.x = put_byte(regs.x, psh_hilon, pul_data);
            else if (psh_bit[kcpu_regs_pkg::PSH_Y])
                nx.y = put_byte(regs.y, psh_hilon, pul_data);
            else if (psh_bit[kcpu_regs_pkg::PSH_OTHER] && psh_ussel)
                nx.s = put_byte(regs.s, psh_hilon, pul_data);
            else if (psh_bit[kcpu_regs_pkg::PSH_OTHER])
                nx.u = put_byte(regs.u, psh_hilon, pul_data);
            else
                nx.pc = put_byte(regs.pc, psh_hilon, pul_data);
            // pointer steps past the byte just read
            if (psh_ussel)
                nx.u = regs.u + 16'd1;
            else
                nx.s = regs.s + 16'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            regs <= '0;
        else
            regs <= nx;
    end

    // controller strobes and the pull path never write on the same edge
    assert property (@(posedge clk) disable iff (rst)
        !(wr_en && (exg_en || pul_en)));

endmodule

// ==== common/kcpu_cmd_pkg.sv ====
/*
 * command port and stack bus definitions
 * command codes, command and response structs,
 * stack RAM request struct
 */
package kcpu_cmd_pkg;

    typedef enum logic [2:0] {
        OP_LOAD = 3'd0,
        OP_READ = 3'd1,
        OP_TFR  = 3'd2,
        OP_EXG  = 3'd3,
        OP_PUSH = 3'd4,
        OP_PULL = 3'd5
    } cmd_op_e;

    // ussel set means the stack goes through U
    typedef struct packed {
        cmd_op_e                  op;
        kcpu_regs_pkg::reg_code_e src;
        kcpu_regs_pkg::reg_code_e dst;
        logic [15:0]              data;
        logic [7:0]               mask;
        logic                     ussel;
    } cmd_t;

    // read value, zero for other commands
    typedef struct packed {
        logic [15:0] data;
    } rsp_t;

    typedef struct packed {
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } stk_req_t;

endpackage

// ==== common/kcpu_regs_pkg.sv ====
/*
 * register file definitions of the KCPU core
 * register selector codes, CC flag positions,
 * push/pull mask bit order and the register snapshot
 */
package kcpu_regs_pkg;

    // codes 0..5 follow the TFR/EXG postbyte encoding
    typedef enum logic [3:0] {
        REG_A  = 4'd0,
        REG_B  = 4'd1,
        REG_X  = 4'd2,
        REG_Y  = 4'd3,
        REG_S  = 4'd4,
        REG_U  = 4'd5,
        REG_DP = 4'd8,
        REG_CC = 4'd9,
        REG_PC = 4'd10
    } reg_code_e;

    // flag positions in CC
    localparam int CC_I = 4;
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    // push/pull postbyte bit order, OTHER is the stack pointer not in use
    typedef enum logic [2:0] {
        PSH_CC    = 3'd0,
        PSH_A     = 3'd1,
        PSH_B     = 3'd2,
        PSH_DP    = 3'd3,
        PSH_X     = 3'd4,
        PSH_Y     = 3'd5,
        PSH_OTHER = 3'd6,
        PSH_PC    = 3'd7
    } psh_bit_e;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  dp;
        logic [7:0]  cc;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] u;
        logic [15:0] s;
        logic [15:0] pc;
    } reg_snap_t;

endpackage
